//--- include/link_bridge_cfg.svh
// Sizes shared by both directions and the FIFO depth is always a power of two
`ifndef LINK_BRIDGE_CFG_SVH
`define LINK_BRIDGE_CFG_SVH

// ========================================
// Link sizing
// ========================================

// Bits in one off-chip data beat
`define LINK_DATA_W 128

// FIFO address bits, depth is 2**LINK_FIFO_AW
`define LINK_FIFO_AW 2

`endif

//--- design/link_bridge_pkg.sv
// Shared types for the link bridge and the FIFO entry layout is {data, last, tag}
`default_nettype none

`include "link_bridge_cfg.svh"

package link_bridge_pkg;

    // ========================================
    // Vector types
    // ========================================

    // One data beat as it crosses the link
    typedef logic [`LINK_DATA_W-1:0] data_t;

    // Buffered beat, bit 1 is last and bit 0 is the tag
    // Tag means ISA inbound and command outbound
    typedef logic [`LINK_DATA_W+1:0] entry_t;

    // FIFO pointer with one extra wrap bit
    typedef logic [`LINK_FIFO_AW:0] ptr_t;

    // ========================================
    // Direction state
    // ========================================

    typedef enum logic [1:0] {
        DIR_IDLE     = 2'd0,
        DIR_INBOUND  = 2'd1,
        DIR_OUTBOUND = 2'd2
    } dir_state_e;

endpackage

`default_nettype wire

//--- design/link_fifo.sv
// Single-clock FWFT buffer, callers must not push when full or pop when empty
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module link_fifo (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          push_i,
    input  wire link_bridge_pkg::entry_t entry_i,
    input  wire                          pop_i,
    output link_bridge_pkg::entry_t      entry_o,
    output logic                         empty_o,
    output logic                         full_o
);
    import link_bridge_pkg::*;

    localparam int DEPTH = 1 << `LINK_FIFO_AW;

    entry_t mem [DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;

    // ========================================
    // Pointers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i && !full_o) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_i && !full_o) begin
            mem[wr_ptr[`LINK_FIFO_AW-1:0]] <= entry_i;
        end
    end

    // Head entry is valid whenever not empty
    assign entry_o = mem[rd_ptr[`LINK_FIFO_AW-1:0]];

    // Same index, wrap bits differ when full
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[`LINK_FIFO_AW] != rd_ptr[`LINK_FIFO_AW]) &&
                     (wr_ptr[`LINK_FIFO_AW-1:0] == rd_ptr[`LINK_FIFO_AW-1:0]);

    // ========================================
    // Checks
    // ========================================

    // Writer must honour full through its ready
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
    ) else $error("link_fifo push while full");

    // Reader pops only a presented head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
    ) else $error("link_fifo pop while empty");

endmodule

`default_nettype wire

//--- design/link_dir_fsm.sv
// Half-duplex link owner, inbound wins a tie in idle and one packet is carried per grant
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module link_dir_fsm (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  off_vld_i,
    input  wire  out_req_i,
    input  wire  in_done_i,
    input  wire  out_done_i,
    output logic in_en_o,
    output logic out_en_o,
    output logic oe_o
);
    import link_bridge_pkg::*;

    dir_state_e state_q;
    dir_state_e state_d;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            DIR_IDLE: begin
                // Off-chip traffic first
                if (off_vld_i) begin
                    state_d = DIR_INBOUND;
                end else if (out_req_i) begin
                    state_d = DIR_OUTBOUND;
                end
            end
            DIR_INBOUND: begin
                if (in_done_i) begin
                    state_d = DIR_IDLE;
                end
            end
            DIR_OUTBOUND: begin
                if (out_done_i) begin
                    state_d = DIR_IDLE;
                end
            end
            default: state_d = DIR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Enables decoded straight from the state
    assign in_en_o  = (state_q == DIR_INBOUND);
    assign out_en_o = (state_q == DIR_OUTBOUND);
    // Pads drive only while transmitting
    assign oe_o     = (state_q == DIR_OUTBOUND);

    a_dir_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(in_en_o && out_en_o)
    ) else $error("link_dir_fsm both directions enabled");

    // Packet ends only arrive from the direction that owns the link
    a_done_dir: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_done_i |-> in_en_o) and (out_done_i |-> out_en_o)
    ) else $error("link_dir_fsm done from idle direction");

endmodule

`default_nettype wire

//--- design/inbound_path.sv
// Inbound buffer taking one packet per grant, head beat routed to CCU on ISA else to GIC
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module inbound_path (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_en_i,
    input  wire                         off_vld_i,
    input  wire link_bridge_pkg::data_t off_dat_i,
    input  wire                         off_last_i,
    input  wire                         off_isa_i,
    output logic                        off_rdy_o,
    output logic                        ccu_vld_o,
    output link_bridge_pkg::data_t      ccu_dat_o,
    output logic                        ccu_last_o,
    input  wire                         ccu_rdy_i,
    output logic                        gic_vld_o,
    output link_bridge_pkg::data_t      gic_dat_o,
    output logic                        gic_last_o,
    input  wire                         gic_rdy_i,
    output logic                        in_done_o
);
    import link_bridge_pkg::*;

    entry_t push_entry;
    entry_t head;
    logic   push;
    logic   pop;
    logic   empty;
    logic   full;
    logic   got_last_q;

    // ========================================
    // Off-chip side
    // ========================================

    // Stop taking beats once the packet end is buffered
    assign off_rdy_o  = in_en_i && !full && !got_last_q;
    assign push       = off_vld_i && off_rdy_o;
    assign push_entry = {off_dat_i, off_last_i, off_isa_i};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            got_last_q <= 1'b0;
        end else if (in_done_o) begin
            got_last_q <= 1'b0;
        end else if (push && off_last_i) begin
            got_last_q <= 1'b1;
        end
    end

    link_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (push),
        .entry_i (push_entry),
        .pop_i   (pop),
        .entry_o (head),
        .empty_o (empty),
        .full_o  (full)
    );

    // ========================================
    // Routing
    // ========================================
    assign ccu_vld_o  = !empty && head[0];
    assign gic_vld_o  = !empty && !head[0];
    assign ccu_dat_o  = head[`LINK_DATA_W+1:2];
    assign gic_dat_o  = head[`LINK_DATA_W+1:2];
    assign ccu_last_o = head[1];
    assign gic_last_o = head[1];

    assign pop       = (ccu_vld_o && ccu_rdy_i) || (gic_vld_o && gic_rdy_i);
    assign in_done_o = pop && head[1];

    // Stalled beats stay put on their port
    a_ccu_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        ccu_vld_o && !ccu_rdy_i |=> ccu_vld_o && $stable(ccu_dat_o) && $stable(ccu_last_o)
    ) else $error("inbound_path CCU beat changed under stall");

    a_gic_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        gic_vld_o && !gic_rdy_i |=> gic_vld_o && $stable(gic_dat_o) && $stable(gic_last_o)
    ) else $error("inbound_path GIC beat changed under stall");

endmodule

`default_nettype wire

//--- design/outbound_arbiter.sv
// Packet arbiter with monitor priority at packet start, one packet is pushed per outbound grant
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module outbound_arbiter (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         out_en_i,
    input  wire                         full_i,
    input  wire                         gic_vld_i,
    input  wire link_bridge_pkg::data_t gic_dat_i,
    input  wire                         gic_last_i,
    input  wire                         gic_cmd_i,
    output logic                        gic_rdy_o,
    input  wire                         mon_vld_i,
    input  wire link_bridge_pkg::data_t mon_dat_i,
    input  wire                         mon_last_i,
    output logic                        mon_rdy_o,
    output logic                        req_o,
    output logic                        push_o,
    output link_bridge_pkg::entry_t     entry_o
);
    import link_bridge_pkg::*;

    // One-hot grant, bit 1 monitor and bit 0 GIC
    localparam logic [1:0] GNT_NONE = 2'b00;
    localparam logic [1:0] GNT_GIC  = 2'b01;
    localparam logic [1:0] GNT_MON  = 2'b10;

    logic [1:0] gnt_q;
    logic [1:0] gnt;
    logic [1:0] pick;
    logic       sent_q;
    logic       open;
    data_t      sel_dat;
    logic       sel_last;
    logic       sel_cmd;

    // ========================================
    // Selection
    // ========================================

    // Monitor first when a new packet starts
    assign pick = mon_vld_i ? GNT_MON : (gic_vld_i ? GNT_GIC : GNT_NONE);
    assign gnt  = (gnt_q != GNT_NONE) ? gnt_q : pick;

    // Room to push and the packet of this grant not yet complete
    assign open      = out_en_i && !full_i && !sent_q;
    assign gic_rdy_o = open && gnt[0];
    assign mon_rdy_o = open && gnt[1];
    assign push_o    = (gic_vld_i && gic_rdy_o) || (mon_vld_i && mon_rdy_o);

    assign req_o = gic_vld_i || mon_vld_i;

    // Monitor beats are never commands
    assign sel_dat  = gnt[1] ? mon_dat_i  : gic_dat_i;
    assign sel_last = gnt[1] ? mon_last_i : gic_last_i;
    assign sel_cmd  = gnt[1] ? 1'b0       : gic_cmd_i;
    assign entry_o  = {sel_dat, sel_last, sel_cmd};

    // ========================================
    // Grant and packet tracking
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q  <= GNT_NONE;
            sent_q <= 1'b0;
        end else begin
            if (push_o) begin
                gnt_q <= sel_last ? GNT_NONE : gnt;
            end
            // Cleared once the FSM leaves outbound
            if (!out_en_i) begin
                sent_q <= 1'b0;
            end else if (push_o && sel_last) begin
                sent_q <= 1'b1;
            end
        end
    end

    // Packets never interleave in the outbound buffer
    a_gnt_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (gnt_q != GNT_NONE) |=> (gnt_q == $past(gnt_q)) || (gnt_q == GNT_NONE)
    ) else $error("outbound_arbiter grant switched mid-packet");

endmodule

`default_nettype wire

//--- design/outbound_path.sv
// Outbound buffer presented off-chip only while the link is owned for transmit
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module outbound_path (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          out_en_i,
    input  wire                          push_i,
    input  wire link_bridge_pkg::entry_t entry_i,
    output logic                         full_o,
    output logic                         off_vld_o,
    output link_bridge_pkg::data_t       off_dat_o,
    output logic                         off_last_o,
    output logic                         off_cmd_o,
    input  wire                          off_rdy_i,
    output logic                         out_done_o
);
    import link_bridge_pkg::*;

    entry_t head;
    logic   empty;
    logic   pop;

    link_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (push_i),
        .entry_i (entry_i),
        .pop_i   (pop),
        .entry_o (head),
        .empty_o (empty),
        .full_o  (full_o)
    );

    // ========================================
    // Off-chip transmit
    // ========================================
    assign off_vld_o  = out_en_i && !empty;
    assign off_dat_o  = head[`LINK_DATA_W+1:2];
    assign off_last_o = head[1];
    assign off_cmd_o  = head[0];

    assign pop        = off_vld_o && off_rdy_i;
    assign out_done_o = pop && head[1];

    // Link stays ours until the beat is taken
    a_off_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        off_vld_o && !off_rdy_i |=> off_vld_o && $stable(head)
    ) else $error("outbound_path off-chip beat dropped under stall");

endmodule

`default_nettype wire

//--- design/link_bridge_top.sv
// Single clock domain bridge with split data-in and data-out ports, pads and PLL live outside
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module link_bridge_top (
    input  wire                         clk,
    input  wire                         rst_n,
    // Off-chip inbound
    input  wire                         off_vld_i,
    input  wire link_bridge_pkg::data_t off_dat_i,
    input  wire                         off_last_i,
    input  wire                         off_isa_i,
    output logic                        off_rdy_o,
    // Off-chip outbound
    output logic                        off_vld_o,
    output link_bridge_pkg::data_t      off_dat_o,
    output logic                        off_last_o,
    output logic                        off_cmd_o,
    input  wire                         off_rdy_i,
    output logic                        oe_o,
    // CCU instruction port
    output logic                        ccu_vld_o,
    output link_bridge_pkg::data_t      ccu_dat_o,
    output logic                        ccu_last_o,
    input  wire                         ccu_rdy_i,
    // GIC inbound
    output logic                        gic_vld_o,
    output link_bridge_pkg::data_t      gic_dat_o,
    output logic                        gic_last_o,
    input  wire                         gic_rdy_i,
    // GIC outbound source
    input  wire                         gic_vld_i,
    input  wire link_bridge_pkg::data_t gic_dat_i,
    input  wire                         gic_last_i,
    input  wire                         gic_cmd_i,
    output logic                        gic_rdy_o,
    // Monitor source
    input  wire                         mon_vld_i,
    input  wire link_bridge_pkg::data_t mon_dat_i,
    input  wire                         mon_last_i,
    output logic                        mon_rdy_o
);

    logic                    in_en;
    logic                    out_en;
    logic                    in_done;
    logic                    out_done;
    logic                    req;
    logic                    push;
    logic                    full;
    link_bridge_pkg::entry_t entry;

    // ========================================
    // Direction control
    // ========================================
    link_dir_fsm u_dir_fsm (
        .clk(clk), .rst_n(rst_n),
        .off_vld_i(off_vld_i), .out_req_i(req),
        .in_done_i(in_done), .out_done_i(out_done),
        .in_en_o(in_en), .out_en_o(out_en), .oe_o(oe_o)
    );

    // ========================================
    // Inbound
    // ========================================
    inbound_path u_inbound (
        .clk(clk), .rst_n(rst_n), .in_en_i(in_en),
        .off_vld_i(off_vld_i), .off_dat_i(off_dat_i),
        .off_last_i(off_last_i), .off_isa_i(off_isa_i), .off_rdy_o(off_rdy_o),
        .ccu_vld_o(ccu_vld_o), .ccu_dat_o(ccu_dat_o),
        .ccu_last_o(ccu_last_o), .ccu_rdy_i(ccu_rdy_i),
        .gic_vld_o(gic_vld_o), .gic_dat_o(gic_dat_o),
        .gic_last_o(gic_last_o), .gic_rdy_i(gic_rdy_i),
        .in_done_o(in_done)
    );

    // ========================================
    // Outbound
    // ========================================
    outbound_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .out_en_i(out_en), .full_i(full),
        .gic_vld_i(gic_vld_i), .gic_dat_i(gic_dat_i), .gic_last_i(gic_last_i),
        .gic_cmd_i(gic_cmd_i), .gic_rdy_o(gic_rdy_o),
        .mon_vld_i(mon_vld_i), .mon_dat_i(mon_dat_i), .mon_last_i(mon_last_i),
        .mon_rdy_o(mon_rdy_o),
        .req_o(req), .push_o(push), .entry_o(entry)
    );

    outbound_path u_outbound (
        .clk(clk), .rst_n(rst_n), .out_en_i(out_en),
        .push_i(push), .entry_i(entry), .full_o(full),
        .off_vld_o(off_vld_o), .off_dat_o(off_dat_o), .off_last_o(off_last_o),
        .off_cmd_o(off_cmd_o), .off_rdy_i(off_rdy_i),
        .out_done_o(out_done)
    );

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
// 4 ns clock, reset goes low at 1 ns and is released 1 ns after the third rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Falling edge before the first clock so the async reset is seen
    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/link_bridge_tb.sv
// Sources hold one beat until taken; off-chip order assumes GIC and monitor load in one cycle
`timescale 1ns/1ps
`default_nettype none

`include "link_bridge_cfg.svh"

module link_bridge_tb;
    import link_bridge_pkg::*;

    localparam int DW = `LINK_DATA_W;

    logic  clk;
    logic  rst_n;
    logic  off_vld_i, off_last_i, off_isa_i, off_rdy_o;
    data_t off_dat_i;
    logic  off_vld_o, off_last_o, off_cmd_o, off_rdy_i, oe_o;
    data_t off_dat_o;
    logic  ccu_vld_o, ccu_last_o, ccu_rdy_i;
    data_t ccu_dat_o;
    logic  gic_vld_o, gic_last_o, gic_rdy_i;
    data_t gic_dat_o;
    logic  gic_vld_i, gic_last_i, gic_cmd_i, gic_rdy_o;
    data_t gic_dat_i;
    logic  mon_vld_i, mon_last_i, mon_rdy_o;
    data_t mon_dat_i;

    // Beats waiting to be driven, and beats expected at each output port
    entry_t drv_in[$];
    entry_t drv_gic[$];
    entry_t drv_mon[$];
    entry_t exp_ccu[$];
    entry_t exp_gic[$];
    entry_t exp_off[$];
    entry_t pend_gic[$];
    entry_t pend_mon[$];

    logic [31:0] lfsr_q = 32'h5ea83f69;
    data_t       stall_bits;
    logic        stall_en = 1'b0;
    int          test_id = 1;
    int          errors = 0;
    int          err_mark = 0;
    int          beats = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          cycles = 0;
    int          cycle_limit = 200;

    tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    link_bridge_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .off_vld_i(off_vld_i), .off_dat_i(off_dat_i), .off_last_i(off_last_i),
        .off_isa_i(off_isa_i), .off_rdy_o(off_rdy_o),
        .off_vld_o(off_vld_o), .off_dat_o(off_dat_o), .off_last_o(off_last_o),
        .off_cmd_o(off_cmd_o), .off_rdy_i(off_rdy_i), .oe_o(oe_o),
        .ccu_vld_o(ccu_vld_o), .ccu_dat_o(ccu_dat_o), .ccu_last_o(ccu_last_o),
        .ccu_rdy_i(ccu_rdy_i),
        .gic_vld_o(gic_vld_o), .gic_dat_o(gic_dat_o), .gic_last_o(gic_last_o),
        .gic_rdy_i(gic_rdy_i),
        .gic_vld_i(gic_vld_i), .gic_dat_i(gic_dat_i), .gic_last_i(gic_last_i),
        .gic_cmd_i(gic_cmd_i), .gic_rdy_o(gic_rdy_o),
        .mon_vld_i(mon_vld_i), .mon_dat_i(mon_dat_i), .mon_last_i(mon_last_i),
        .mon_rdy_o(mon_rdy_o)
    );

    // ========================================
    // Random source and packet builder
    // ========================================

    // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[i]   = lfsr_q[0];
        end
    endtask

    // Source 0 is off-chip inbound, 1 is GIC outbound, 2 is the monitor
    task automatic make_packet(input int src);
        data_t  bits;
        data_t  dat;
        entry_t beat;
        int     len;
        logic   tag;
        logic   last;
        draw_bits(3, bits);
        len = 1 + int'(bits[2:0]);
        draw_bits(1, bits);
        tag = (src == 2) ? 1'b0 : bits[0];
        for (int i = 0; i < len; i++) begin
            draw_bits(DW, dat);
            last = (i == len - 1);
            beat = {dat, last, tag};
            if (src == 0) begin
                drv_in.push_back(beat);
                if (tag) begin
                    exp_ccu.push_back(beat);
                end else begin
                    exp_gic.push_back(beat);
                end
            end else if (src == 1) begin
                drv_gic.push_back(beat);
                pend_gic.push_back(beat);
            end else begin
                drv_mon.push_back(beat);
                pend_mon.push_back(beat);
            end
        end
        beats       += len;
        cycle_limit += 20 * len;
    endtask

    // Monitor wins every packet start while both wait, so all its packets lead
    task automatic expect_outbound();
        while (pend_mon.size() != 0) begin
            exp_off.push_back(pend_mon.pop_front());
        end
        while (pend_gic.size() != 0) begin
            exp_off.push_back(pend_gic.pop_front());
        end
    endtask

    // ========================================
    // Drivers
    // ========================================
    always @(posedge clk) begin
        if (off_vld_i && off_rdy_o) begin
            drv_in.delete(0);
        end
        #1;
        off_vld_i = (drv_in.size() != 0);
        if (off_vld_i) begin
            {off_dat_i, off_last_i, off_isa_i} = drv_in[0];
        end
    end

    always @(posedge clk) begin
        if (gic_vld_i && gic_rdy_o) begin
            drv_gic.delete(0);
        end
        #1;
        gic_vld_i = (drv_gic.size() != 0);
        if (gic_vld_i) begin
            {gic_dat_i, gic_last_i, gic_cmd_i} = drv_gic[0];
        end
    end

    always @(posedge clk) begin
        if (mon_vld_i && mon_rdy_o) begin
            drv_mon.delete(0);
        end
        #1;
        mon_vld_i = (drv_mon.size() != 0);
        if (mon_vld_i) begin
            {mon_dat_i, mon_last_i} = drv_mon[0][DW+1:1];
        end
    end

    // Sink readiness, random only while stalls are on
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            draw_bits(3, stall_bits);
            off_rdy_i = stall_bits[0];
            ccu_rdy_i = stall_bits[1];
            gic_rdy_i = stall_bits[2];
        end else begin
            off_rdy_i = 1'b1;
            ccu_rdy_i = 1'b1;
            gic_rdy_i = 1'b1;
        end
    end

    // ========================================
    // Scoreboard
    // ========================================
    task automatic flag_failure(input string what);
        $display("error at time %0t: %s", $time, what);
        errors++;
    endtask

    task automatic report_extra(input string port);
        flag_failure({"beat on ", port, " port with none expected"});
    endtask

    task automatic compare_beat(input string port, input entry_t exp, input entry_t got,
                                input logic has_tag);
        assert (got[DW+1:2] === exp[DW+1:2]) else begin
            $display("mismatch at time %0t: %s_dat_o got %h expected %h",
                     $time, port, got[DW+1:2], exp[DW+1:2]);
            errors++;
        end
        assert (got[1] === exp[1]) else begin
            $display("mismatch at time %0t: %s_last_o got %b expected %b",
                     $time, port, got[1], exp[1]);
            errors++;
        end
        if (has_tag) begin
            assert (got[0] === exp[0]) else begin
                $display("mismatch at time %0t: %s_cmd_o got %b expected %b",
                         $time, port, got[0], exp[0]);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (ccu_vld_o && ccu_rdy_i) begin
                if (exp_ccu.size() == 0) begin
                    report_extra("ccu");
                end else begin
                    compare_beat("ccu", exp_ccu.pop_front(), {ccu_dat_o, ccu_last_o, 1'b1}, 1'b0);
                end
            end
            if (gic_vld_o && gic_rdy_i) begin
                if (exp_gic.size() == 0) begin
                    report_extra("gic");
                end else begin
                    compare_beat("gic", exp_gic.pop_front(), {gic_dat_o, gic_last_o, 1'b0}, 1'b0);
                end
            end
            if (off_vld_o && off_rdy_i) begin
                if (exp_off.size() == 0) begin
                    report_extra("off-chip");
                end else begin
                    compare_beat("off", exp_off.pop_front(), {off_dat_o, off_last_o, off_cmd_o},
                                 1'b1);
                end
            end
            // Tied request, inbound must finish before any transmit
            if (test_id == 6) begin
                assert (!(off_vld_o && (exp_ccu.size() + exp_gic.size() != 0))) else begin
                    flag_failure("off-chip transmit began before the inbound packet was delivered");
                end
            end
        end
    end

    // ========================================
    // Protocol checks
    // ========================================
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n || $rose(rst_n) |-> !(off_rdy_o || off_vld_o || ccu_vld_o || gic_vld_o ||
                                     gic_rdy_o || mon_rdy_o || oe_o))
        else flag_failure("valid, ready or oe_o high during or right after reset");

    a_link_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(off_rdy_o && off_vld_o))
        else flag_failure("off_rdy_o and off_vld_o high together");

    a_oe_tx: assert property (@(posedge clk) disable iff (!rst_n) off_vld_o |-> oe_o)
        else flag_failure("off_vld_o high while oe_o low");

    a_inbound_oe: assert property (@(posedge clk) disable iff (!rst_n) test_id == 2 |-> !oe_o)
        else flag_failure("oe_o high during inbound-only traffic");

    a_off_hold: assert property (@(posedge clk) disable iff (!rst_n)
        off_vld_o && !off_rdy_i |=> off_vld_o && $stable({off_dat_o, off_last_o, off_cmd_o}))
        else flag_failure("off-chip beat changed while stalled");

    a_ccu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ccu_vld_o && !ccu_rdy_i |=> ccu_vld_o && $stable({ccu_dat_o, ccu_last_o}))
        else flag_failure("CCU beat changed while stalled");

    a_gic_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gic_vld_o && !gic_rdy_i |=> gic_vld_o && $stable({gic_dat_o, gic_last_o}))
        else flag_failure("GIC beat changed while stalled");

    // ========================================
    // Sequencing and reporting
    // ========================================
    function automatic int outstanding();
        return drv_in.size() + drv_gic.size() + drv_mon.size() +
               exp_ccu.size() + exp_gic.size() + exp_off.size();
    endfunction

    task automatic wait_drained();
        while (outstanding() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic start_test(input int id);
        test_id  = id;
        err_mark = errors;
        beats    = 0;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = errors - err_mark;
        if (errs != 0) begin
            tests_bad++;
        end
        tests_run++;
        $display("test %0d %s: %0d beats, %0d errors", test_id, name, beats, errs);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d beats outstanding", cycles, outstanding());
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        off_vld_i  = 1'b0;
        off_dat_i  = '0;
        off_last_i = 1'b0;
        off_isa_i  = 1'b0;
        off_rdy_i  = 1'b0;
        ccu_rdy_i  = 1'b0;
        gic_rdy_i  = 1'b0;
        gic_vld_i  = 1'b0;
        gic_dat_i  = '0;
        gic_last_i = 1'b0;
        gic_cmd_i  = 1'b0;
        mon_vld_i  = 1'b0;
        mon_dat_i  = '0;
        mon_last_i = 1'b0;

        // Reset is first asserted, then released
        start_test(1);
        wait (rst_n === 1'b0);
        @(posedge rst_n);
        repeat (5) @(negedge clk);
        end_test("reset");

        start_test(2);
        for (int i = 0; i < 4; i++) begin
            make_packet(0);
        end
        wait_drained();
        end_test("inbound routing");

        start_test(3);
        for (int i = 0; i < 4; i++) begin
            make_packet(1);
        end
        expect_outbound();
        wait_drained();
        end_test("gic outbound");

        start_test(4);
        for (int i = 0; i < 3; i++) begin
            make_packet(1);
            make_packet(2);
        end
        expect_outbound();
        wait_drained();
        end_test("arbitration");

        // Both directions loaded with random sink stalls
        start_test(5);
        stall_en = 1'b1;
        for (int i = 0; i < 3; i++) begin
            make_packet(0);
            make_packet(1);
            make_packet(2);
        end
        make_packet(0);
        expect_outbound();
        wait_drained();
        stall_en = 1'b0;
        end_test("back-pressure");

        start_test(6);
        make_packet(0);
        make_packet(1);
        expect_outbound();
        wait_drained();
        end_test("direction exclusivity");

        $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- link_bridge.f
+incdir+include
design/link_bridge_pkg.sv
design/link_fifo.sv
design/link_dir_fsm.sv
design/inbound_path.sv
design/outbound_arbiter.sv
design/outbound_path.sv
design/link_bridge_top.sv
sim/tb_clkgen.sv
sim/link_bridge_tb.sv
